//--- flist.f
+incdir+.
le_pkg.sv
le_frame_regs.sv
le_control.sv
le_r_bin_calc.sv
le_theta_histogram.sv
le_max_finder.sv
le_top.sv
le_asserts.sv
tb_le_checker.sv
tb_le_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_le_top -o sim_le > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_le +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi
if ! grep -q "all tests passed" sim.log; then
   echo "no pass line found in sim.log"
   exit 1
fi
exit 0

//--- tb_le_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module tb_clkgen #(
   parameter int HALF_PERIOD = 20
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;   // 40 ns period
   end

endmodule

module tb_le_top
   import le_pkg::*;
;

   localparam logic [31:0] LFSR_SEED = 32'h203c0970;
   localparam int N_RAND    = 6;
   localparam int N_FRAMES  = 2 * N_RAND + 5;
   localparam int MAX_HITS  = 31;
   localparam int MAX_GAP   = 3;
   localparam int WATCHDOG_CYCLES = N_FRAMES * (MAX_HITS + MAX_HITS * MAX_GAP + 40) + 20;

   logic                    clk;
   logic                    rst_n_i;
   roi_t                    roi_i;
   logic                    roi_empty_i;
   logic                    roi_re_o;
   logic [`LE_HITCNT_W-1:0] hit_count_i;
   hit_t                    hit_i;
   logic                    hit_empty_i;
   logic                    hit_re_o;
   theta_idx_t              result_theta_o;
   r_bin_t                  result_r_bin_o;
   count_t                  result_count_o;
   logic                    result_vld_o;
   int                      frames_done;
   int                      error_count;

   logic [31:0] lfsr_state;
   logic [`LE_HITCNT_W+`LE_POS_W-1:0] roi_q [$];   // {hit count, r_min}
   logic [28:0]                       hit_q [$];   // {gap, y, z}
   logic [28:0]                       hit_head;

   tb_clkgen clkgen0 (.clk(clk));

   le_top dut0 (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .roi_i          (roi_i),
      .roi_empty_i    (roi_empty_i),
      .roi_re_o       (roi_re_o),
      .hit_count_i    (hit_count_i),
      .hit_i          (hit_i),
      .hit_empty_i    (hit_empty_i),
      .hit_re_o       (hit_re_o),
      .result_theta_o (result_theta_o),
      .result_r_bin_o (result_r_bin_o),
      .result_count_o (result_count_o),
      .result_vld_o   (result_vld_o)
   );

   tb_le_checker chk0 (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .roi_i          (roi_i),
      .roi_empty_i    (roi_empty_i),
      .roi_re_o       (roi_re_o),
      .hit_count_i    (hit_count_i),
      .hit_i          (hit_i),
      .hit_empty_i    (hit_empty_i),
      .hit_re_o       (hit_re_o),
      .result_theta_o (result_theta_o),
      .result_r_bin_o (result_r_bin_o),
      .result_count_o (result_count_o),
      .result_vld_o   (result_vld_o),
      .frames_o       (frames_done),
      .errors_o       (error_count)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   task automatic add_roi(input int r_min, input int n);
      roi_q.push_back({n[`LE_HITCNT_W-1:0], pos_t'(r_min)});
   endtask

   task automatic add_hit(input int z, input int y, input int gap);
      hit_q.push_back({gap[4:0], pos_t'(y), pos_t'(z)});
   endtask

   task automatic add_random_frame(input int gap_bits);
      int n;
      int r_min;
      r_min = rand_bits(8) - 160;
      n     = rand_bits(5);
      add_roi(r_min, n);
      for (int i = 0; i < n; i++)
         add_hit(rand_bits(8) - 128, rand_bits(8) - 128, rand_bits(gap_bits));
   endtask

   task automatic build_frames();
      add_roi(60, 12);                  // line z + y = 100 lands in theta 2 bin 2
      for (int k = -6; k < 6; k++)
         add_hit(50 + 3 * k, 50 - 3 * k, 0);
      for (int f = 0; f < N_RAND; f++)
         add_random_frame(0);
      add_roi(1000, 8);                 // every radius below r_min
      for (int i = 0; i < 8; i++)
         add_hit(rand_bits(8) - 128, rand_bits(8) - 128, 0);
      add_roi(-500, 8);                 // every radius above the window
      for (int i = 0; i < 8; i++)
         add_hit(rand_bits(8) - 128, rand_bits(8) - 128, 0);
      add_roi(-40, 20);
      for (int i = 0; i < 20; i++)
         add_hit(10, 20, 0);
      add_roi(0, 0);
      for (int f = 0; f < N_RAND; f++)
         add_random_frame(2);           // with empty gaps up to 3 cycles
   endtask

   // FWFT ROI FIFO with the hit count in each entry
   always @(posedge clk)
   begin
      if (roi_re_o)
         roi_q.delete(0);
      roi_empty_i <= (roi_q.size() == 0);
      if (roi_q.size() != 0)
         {hit_count_i, roi_i} <= roi_q[0];
   end

   // FWFT hit FIFO that holds its head back while the gap runs down
   always @(posedge clk)
   begin
      if (hit_re_o)
         hit_q.delete(0);
      else if (hit_q.size() != 0 && hit_q[0][28:24] != 5'd0)
      begin
         hit_head = hit_q[0];
         hit_head[28:24] = hit_head[28:24] - 5'd1;
         hit_q[0] = hit_head;
      end
      if (hit_q.size() != 0)
      begin
         hit_i       <= hit_q[0][23:0];
         hit_empty_i <= (hit_q[0][28:24] != 5'd0);
      end
      else
         hit_empty_i <= 1'b1;
   end

   initial
   begin
      rst_n_i     = 1'b0;
      roi_i       = '0;
      roi_empty_i = 1'b1;
      hit_count_i = '0;
      hit_i       = '0;
      hit_empty_i = 1'b1;
      lfsr_state  = LFSR_SEED;
      build_frames();
      repeat (10) @(posedge clk);
      rst_n_i <= 1'b1;
      wait (frames_done == N_FRAMES);
      repeat (4) @(posedge clk);
      $display("%0d of %0d frames checked, %0d errors", frames_done, N_FRAMES, error_count);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles with %0d of %0d frames done", WATCHDOG_CYCLES,
               frames_done, N_FRAMES);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_le_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module tb_le_checker
   import le_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  roi_t                    roi_i,
   input  logic                    roi_empty_i,
   input  logic                    roi_re_o,
   input  logic [`LE_HITCNT_W-1:0] hit_count_i,
   input  hit_t                    hit_i,
   input  logic                    hit_empty_i,
   input  logic                    hit_re_o,
   input  theta_idx_t              result_theta_o,
   input  r_bin_t                  result_r_bin_o,
   input  count_t                  result_count_o,
   input  logic                    result_vld_o,
   output int                      frames_o,
   output int                      errors_o
);

   localparam int R_SPAN  = `LE_R_BINS << `LE_R_BIN_SHIFT;
   localparam int CNT_SAT = (1 << `LE_CNT_W) - 1;

   int   frames_q   = 0;
   int   errors_q   = 0;
   logic frame_open = 1'b0;
   int   cur_r_min;
   int   cur_count;
   hit_t hits [$];

   // replays the binning, saturation and both tie rules
   function automatic void expected_result(input int r_min, input hit_t hs [$],
                                           output int e_theta, output int e_bin,
                                           output int e_count);
      int   cnt [`LE_THETA_BINS][`LE_R_BINS];
      int   loc_count [`LE_THETA_BINS];
      int   loc_bin [`LE_THETA_BINS];
      int   r;
      int   d;
      int   b;
      hit_t h;
      for (int t = 0; t < `LE_THETA_BINS; t++)
      begin
         loc_count[t] = 0;
         loc_bin[t]   = 0;
         for (int k = 0; k < `LE_R_BINS; k++)
            cnt[t][k] = 0;
      end
      foreach (hs[i])
      begin
         h = hs[i];
         for (int t = 0; t < `LE_THETA_BINS; t++)
         begin
            r = (int'(h.z) * int'(cos_tab[t]) + int'(h.y) * int'(sin_tab[t])) >>> `LE_TRIG_FRAC;
            d = r - r_min;
            if (d >= 0 && d < R_SPAN)
            begin
               b = d >> `LE_R_BIN_SHIFT;
               if (cnt[t][b] < CNT_SAT)
                  cnt[t][b]++;
               if (cnt[t][b] > loc_count[t])   // first bin to reach a count keeps it
               begin
                  loc_count[t] = cnt[t][b];
                  loc_bin[t]   = b;
               end
            end
         end
      end
      e_theta = 0;
      e_bin   = 0;
      e_count = 0;
      for (int t = 0; t < `LE_THETA_BINS; t++)
      begin
         if (loc_count[t] > e_count)
         begin
            e_theta = t;
            e_bin   = loc_bin[t];
            e_count = loc_count[t];
         end
      end
   endfunction

   function automatic int value_mismatch(input string name, input int exp_v, input int act_v);
      if (exp_v == act_v)
         return 0;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
      return 1;
   endfunction

   task automatic compare_frame();
      int e_theta;
      int e_bin;
      int e_count;
      int bad;
      expected_result(cur_r_min, hits, e_theta, e_bin, e_count);
      bad = 0;
      if (!frame_open)
      begin
         $display("%0t result valid without a preceding ROI read", $time);
         bad++;
      end
      if (hits.size() != cur_count)
      begin
         $display("%0t frame read %0d hits but its hit count was %0d", $time, hits.size(),
                  cur_count);
         bad++;
      end
      bad += value_mismatch("result_theta_o", e_theta, int'(result_theta_o));
      bad += value_mismatch("result_r_bin_o", e_bin, int'(result_r_bin_o));
      bad += value_mismatch("result_count_o", e_count, int'(result_count_o));
      errors_q += bad;
      frames_q++;
      $display("frame %0d %s: r_min %0d, %0d hits, theta %0d bin %0d count %0d", frames_q,
               (bad == 0) ? "ok" : "FAIL", cur_r_min, hits.size(), result_theta_o,
               result_r_bin_o, result_count_o);
      frame_open = 1'b0;
   endtask

   always @(posedge clk)
   begin
      if (rst_n_i)
      begin
         if (roi_re_o && roi_empty_i)
         begin
            $display("%0t ROI read while the ROI FIFO is empty", $time);
            errors_q++;
         end
         if (hit_re_o && hit_empty_i)
         begin
            $display("%0t hit read while the hit FIFO is empty", $time);
            errors_q++;
         end
         if (roi_re_o)
         begin
            if (frame_open)
            begin
               $display("%0t second ROI read before the frame result", $time);
               errors_q++;
            end
            frame_open = 1'b1;
            cur_r_min  = int'(roi_i.r_min);
            cur_count  = int'(hit_count_i);
            hits.delete();
         end
         if (hit_re_o)
            hits.push_back(hit_i);
         if (result_vld_o)
            compare_frame();
      end
   end

   assign frames_o = frames_q;
   assign errors_o = errors_q;

endmodule

`default_nettype wire

//--- le_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module le_asserts (
   input logic clk,
   input logic rst_n_i,
   input logic roi_empty_i,
   input logic roi_re_o,
   input logic hit_empty_i,
   input logic hit_re_o,
   input logic result_vld_o
);

   hit_read_not_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(hit_re_o && hit_empty_i))
      else $error("hit read while the hit FIFO is empty");

   roi_read_not_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(roi_re_o && roi_empty_i))
      else $error("ROI read while the ROI FIFO is empty");

   // result valid is a single-cycle pulse
   result_vld_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      result_vld_o |=> !result_vld_o)
      else $error("result valid held for two cycles");

endmodule

bind le_top le_asserts u_asserts (
   .clk          (clk),
   .rst_n_i      (rst_n_i),
   .roi_empty_i  (roi_empty_i),
   .roi_re_o     (roi_re_o),
   .hit_empty_i  (hit_empty_i),
   .hit_re_o     (hit_re_o),
   .result_vld_o (result_vld_o)
);

`default_nettype wire

//--- le_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_top
   import le_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  roi_t                    roi_i,
   input  logic                    roi_empty_i,
   output logic                    roi_re_o,
   input  logic [`LE_HITCNT_W-1:0] hit_count_i,
   input  hit_t                    hit_i,
   input  logic                    hit_empty_i,
   output logic                    hit_re_o,
   output theta_idx_t              result_theta_o,
   output r_bin_t                  result_r_bin_o,
   output count_t                  result_count_o,
   output logic                    result_vld_o
);

   logic   hist_clr;
   logic   scan_start;
   logic   scan_done;
   logic   hits_done;
   pos_t   r_min;
   count_t loc_max_count [`LE_THETA_BINS];
   r_bin_t loc_max_bin [`LE_THETA_BINS];

   le_control u_control (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .roi_empty_i  (roi_empty_i),
      .hit_empty_i  (hit_empty_i),
      .hits_done_i  (hits_done),
      .scan_done_i  (scan_done),
      .roi_re_o     (roi_re_o),
      .hit_re_o     (hit_re_o),
      .hist_clr_o   (hist_clr),
      .scan_start_o (scan_start)
   );

   le_frame_regs u_frame_regs (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .roi_re_i    (roi_re_o),
      .roi_i       (roi_i),
      .hit_count_i (hit_count_i),
      .hit_re_i    (hit_re_o),
      .r_min_o     (r_min),
      .hits_done_o (hits_done)
   );

   // one radius pipeline and histogram per theta
   for (genvar t = 0; t < `LE_THETA_BINS; t++)
   begin : g_theta
      r_bin_t bin;
      logic   bin_vld;

      le_r_bin_calc #(
         .THETA_IDX (t)
      ) u_calc (
         .clk       (clk),
         .rst_n_i   (rst_n_i),
         .hit_vld_i (hit_re_o),   // FWFT head is the hit being read
         .hit_i     (hit_i),
         .r_min_i   (r_min),
         .bin_o     (bin),
         .bin_vld_o (bin_vld)
      );

      le_theta_histogram u_hist (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .clr_i       (hist_clr),
         .bin_i       (bin),
         .bin_vld_i   (bin_vld),
         .max_count_o (loc_max_count[t]),
         .max_bin_o   (loc_max_bin[t])
      );
   end

   le_max_finder u_max_finder (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .start_i        (scan_start),
      .max_count_i    (loc_max_count),
      .max_bin_i      (loc_max_bin),
      .result_theta_o (result_theta_o),
      .result_r_bin_o (result_r_bin_o),
      .result_count_o (result_count_o),
      .result_vld_o   (result_vld_o),
      .done_o         (scan_done)
   );

endmodule

`default_nettype wire

//--- le_max_finder.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_max_finder
   import le_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic       start_i,
   input  count_t     max_count_i [`LE_THETA_BINS],
   input  r_bin_t     max_bin_i [`LE_THETA_BINS],
   output theta_idx_t result_theta_o,
   output r_bin_t     result_r_bin_o,
   output count_t     result_count_o,
   output logic       result_vld_o,
   output logic       done_o
);

   localparam theta_idx_t LAST_IDX = theta_idx_t'(`LE_THETA_BINS - 1);

   logic       busy_q;
   theta_idx_t idx_q;
   theta_idx_t best_theta_q;
   r_bin_t     best_bin_q;
   count_t     best_count_q;
   logic       take;
   theta_idx_t nxt_theta;
   r_bin_t     nxt_bin;
   count_t     nxt_count;
   theta_idx_t res_theta_q;
   r_bin_t     res_bin_q;
   count_t     res_count_q;
   logic       res_vld_q;

   assign take      = max_count_i[idx_q] > best_count_q;   // lowest theta wins a tie
   assign nxt_theta = take ? idx_q : best_theta_q;
   assign nxt_bin   = take ? max_bin_i[idx_q] : best_bin_q;
   assign nxt_count = take ? max_count_i[idx_q] : best_count_q;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q       <= 1'b0;
         idx_q        <= '0;
         best_theta_q <= '0;
         best_bin_q   <= '0;
         best_count_q <= '0;
         res_theta_q  <= '0;
         res_bin_q    <= '0;
         res_count_q  <= '0;
         res_vld_q    <= 1'b0;
      end
      else
      begin
         res_vld_q <= 1'b0;
         if (start_i)
         begin
            busy_q       <= 1'b1;
            idx_q        <= '0;
            best_theta_q <= '0;
            best_bin_q   <= '0;
            best_count_q <= '0;
         end
         else if (busy_q)
         begin
            best_theta_q <= nxt_theta;
            best_bin_q   <= nxt_bin;
            best_count_q <= nxt_count;
            idx_q        <= idx_q + 1'b1;
            if (idx_q == LAST_IDX)
            begin
               busy_q      <= 1'b0;
               res_theta_q <= nxt_theta;   // last compare goes straight out
               res_bin_q   <= nxt_bin;
               res_count_q <= nxt_count;
               res_vld_q   <= 1'b1;
            end
         end
      end
   end

   assign result_theta_o = res_theta_q;
   assign result_r_bin_o = res_bin_q;
   assign result_count_o = res_count_q;
   assign result_vld_o   = res_vld_q;
   assign done_o         = res_vld_q;

endmodule

`default_nettype wire

//--- le_theta_histogram.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_theta_histogram
   import le_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   clr_i,
   input  r_bin_t bin_i,
   input  logic   bin_vld_i,
   output count_t max_count_o,
   output r_bin_t max_bin_o
);

   localparam count_t CNT_MAX = '1;

   count_t cnt_q [`LE_R_BINS];
   count_t cnt_cur;
   count_t cnt_nxt;
   count_t max_count_q;
   r_bin_t max_bin_q;

   assign cnt_cur = cnt_q[bin_i];
   assign cnt_nxt = (cnt_cur == CNT_MAX) ? CNT_MAX : cnt_cur + 1'b1;   // saturate

   // bin counters zeroed by the frame clear
   always_ff @(posedge clk)
   begin
      if (clr_i)
      begin
         for (int i = 0; i < `LE_R_BINS; i++)
            cnt_q[i] <= '0;
      end
      else if (bin_vld_i)
         cnt_q[bin_i] <= cnt_nxt;
   end

   // strictly greater keeps the first bin to reach a count
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         max_count_q <= '0;
         max_bin_q   <= '0;
      end
      else if (clr_i)
      begin
         max_count_q <= '0;
         max_bin_q   <= '0;
      end
      else if (bin_vld_i && (cnt_nxt > max_count_q))
      begin
         max_count_q <= cnt_nxt;
         max_bin_q   <= bin_i;
      end
   end

   assign max_count_o = max_count_q;
   assign max_bin_o   = max_bin_q;

endmodule

`default_nettype wire

//--- le_r_bin_calc.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_r_bin_calc
   import le_pkg::*;
#(
   parameter int THETA_IDX = 0
)
(
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   hit_vld_i,
   input  hit_t   hit_i,
   input  pos_t   r_min_i,
   output r_bin_t bin_o,
   output logic   bin_vld_o
);

   localparam int PROD_W = `LE_POS_W + `LE_TRIG_W;
   localparam int SUM_W  = PROD_W + 1;
   localparam int DIFF_W = SUM_W + 1;
   localparam int R_SPAN = `LE_R_BINS << `LE_R_BIN_SHIFT;   // 64 position units

   localparam trig_t COS_VAL = cos_tab[THETA_IDX];
   localparam trig_t SIN_VAL = sin_tab[THETA_IDX];

   logic signed [PROD_W-1:0] z_cos_q;
   logic signed [PROD_W-1:0] y_sin_q;
   logic signed [SUM_W-1:0]  sum;
   logic signed [SUM_W-1:0]  radius;
   logic signed [DIFF_W-1:0] diff;
   logic [`LE_CALC_LAT-1:0]  vld_q;
   logic                     in_range_q;
   r_bin_t                   bin_q;

   // stage 1
   always_ff @(posedge clk)
   begin
      z_cos_q <= hit_i.z * COS_VAL;
      y_sin_q <= hit_i.y * SIN_VAL;
   end

   assign sum    = z_cos_q + y_sin_q;
   assign radius = sum >>> `LE_TRIG_FRAC;   // floor rather than truncation toward zero
   assign diff   = radius - r_min_i;

   // stage 2
   always_ff @(posedge clk)
   begin
      in_range_q <= (diff >= 0) && (diff < R_SPAN);
      bin_q      <= diff[`LE_R_BIN_SHIFT +: $bits(r_bin_t)];
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[`LE_CALC_LAT-2:0], hit_vld_i};
   end

   assign bin_o     = bin_q;
   assign bin_vld_o = vld_q[`LE_CALC_LAT-1] & in_range_q;

endmodule

`default_nettype wire

//--- le_control.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_control
   import le_pkg::*;
(
   input  logic clk,
   input  logic rst_n_i,
   input  logic roi_empty_i,
   input  logic hit_empty_i,
   input  logic hits_done_i,
   input  logic scan_done_i,
   output logic roi_re_o,
   output logic hit_re_o,
   output logic hist_clr_o,
   output logic scan_start_o
);

   localparam int FLUSH_W = $clog2(`LE_FLUSH_CYCLES + 1);

   le_state_t          state_q;
   le_state_t          state_nxt;
   logic [FLUSH_W-1:0] flush_cnt_q;
   logic               scan_start_q;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         ST_IDLE:
         begin
            if (!roi_empty_i)
               state_nxt = ST_ROI_RD;
         end
         ST_ROI_RD:
            state_nxt = ST_CLEAR;
         ST_CLEAR:
            state_nxt = ST_ACCUM;
         ST_ACCUM:
         begin
            if (hits_done_i)
               state_nxt = ST_FLUSH;
         end
         ST_FLUSH:
         begin
            if (flush_cnt_q == '0)
               state_nxt = ST_SCAN;
         end
         ST_SCAN:
         begin
            if (scan_done_i)
               state_nxt = ST_IDLE;
         end
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q      <= ST_IDLE;
         flush_cnt_q  <= '0;
         scan_start_q <= 1'b0;
      end
      else
      begin
         state_q      <= state_nxt;
         scan_start_q <= (state_q == ST_FLUSH) && (state_nxt == ST_SCAN);
         if (state_q == ST_ACCUM)
            flush_cnt_q <= FLUSH_W'(`LE_FLUSH_CYCLES - 1);   // preload for the drain
         else if (state_q == ST_FLUSH)
            flush_cnt_q <= flush_cnt_q - 1'b1;
      end
   end

   // entry is already at the FIFO head when ROI_RD is reached
   assign roi_re_o     = (state_q == ST_ROI_RD);
   assign hist_clr_o   = (state_q == ST_CLEAR);
   assign hit_re_o     = (state_q == ST_ACCUM) && !hit_empty_i && !hits_done_i;
   assign scan_start_o = scan_start_q;

endmodule

`default_nettype wire

//--- le_frame_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "le_defines.svh"

module le_frame_regs
   import le_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    roi_re_i,
   input  roi_t                    roi_i,
   input  logic [`LE_HITCNT_W-1:0] hit_count_i,
   input  logic                    hit_re_i,
   output pos_t                    r_min_o,
   output logic                    hits_done_o
);

   pos_t                    r_min_q;
   logic [`LE_HITCNT_W-1:0] target_q;
   logic [`LE_HITCNT_W-1:0] consumed_q;

   always_ff @(posedge clk)
   begin
      if (roi_re_i)
         r_min_q <= roi_i.r_min;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         target_q   <= '0;
         consumed_q <= '0;
      end
      else if (roi_re_i)
      begin
         target_q   <= hit_count_i;   // level input sampled here only
         consumed_q <= '0;
      end
      else if (hit_re_i)
         consumed_q <= consumed_q + 1'b1;
   end

   assign r_min_o     = r_min_q;
   assign hits_done_o = (consumed_q == target_q);   // true at once for a zero count

endmodule

`default_nettype wire

//--- le_pkg.sv
`default_nettype none
`include "le_defines.svh"

package le_pkg;

   typedef logic signed [`LE_POS_W-1:0] pos_t;

   typedef struct packed {
      pos_t y;
      pos_t z;                         // low bits
   } hit_t;

   typedef struct packed {
      pos_t r_min;
   } roi_t;

   typedef logic [$clog2(`LE_R_BINS)-1:0]     r_bin_t;
   typedef logic [$clog2(`LE_THETA_BINS)-1:0] theta_idx_t;
   typedef logic [`LE_CNT_W-1:0]              count_t;
   typedef logic signed [`LE_TRIG_W-1:0]      trig_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ROI_RD,
      ST_CLEAR,
      ST_ACCUM,
      ST_FLUSH,
      ST_SCAN
   } le_state_t;

   // 256 is 1.0
   localparam trig_t cos_tab [`LE_THETA_BINS] = '{
      trig_t'(256), trig_t'(237), trig_t'(181), trig_t'(98),
      trig_t'(0), trig_t'(-98), trig_t'(-181), trig_t'(-237)
   };

   localparam trig_t sin_tab [`LE_THETA_BINS] = '{
      trig_t'(0), trig_t'(98), trig_t'(181), trig_t'(237),
      trig_t'(256), trig_t'(237), trig_t'(181), trig_t'(98)
   };

endpackage

`default_nettype wire

//--- le_defines.svh
`ifndef LE_DEFINES_SVH
`define LE_DEFINES_SVH

// histogram geometry
`define LE_THETA_BINS     8     // theta k at k * 22.5 deg
`define LE_R_BINS         16
`define LE_R_BIN_SHIFT    2     // bin width of 4 position units

// arithmetic widths
`define LE_POS_W          12    // signed position
`define LE_TRIG_W         10    // signed Q1.8
`define LE_TRIG_FRAC      8
`define LE_CNT_W          4     // saturating bin count
`define LE_HITCNT_W       8

// latencies
`define LE_CALC_LAT       2     // hit read to bin valid
`define LE_FLUSH_CYCLES   4     // wait after last hit read

`endif
